// ==== files.f ====
mesh_pkg.sv
mesh_round_robin_arbiter.sv
mesh_switch_control.sv
mesh_input_unit.sv
mesh_output_stage.sv
mesh_router.sv
tb_clock_gen.sv
tb_mesh_router_assert.sv
tb_mesh_router.sv

// ==== Makefile ====
# Verilator build and run of the mesh router testbench

VERILATOR ?= verilator
TOP       ?= tb_mesh_router
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from grep, so a missing pass line fails the target
run: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_mesh_router.sv ====
// Mesh router testbench: directed tests, XY / round-robin reference model,
// per-output per-source scoreboard, timeout and summary

module tb_mesh_router;

  import mesh_pkg::*;

  localparam int DATA_W     = 16;
  localparam int COORD_W    = 3;
  localparam int FIFO_DEPTH = 4;
  localparam int ROUTER_X   = 2;
  localparam int ROUTER_Y   = 2;
  localparam int N_RANDOM   = 200;
  localparam int SRC_LSB    = DATA_W - 2 * COORD_W - SEL_W;  // Source tag below Y
  localparam int SEQ_W      = SRC_LSB;
  localparam int N_FLITS    = 5 + 12 + 4 + (FIFO_DEPTH + 1) + N_RANDOM;
  localparam int MAX_CYCLES = 20 * N_FLITS + 200;

  logic              clk;
  logic              rst_n;
  logic [DATA_W-1:0] in_data  [N_PORTS];
  logic              in_val   [N_PORTS];
  logic              in_en    [N_PORTS];
  logic [DATA_W-1:0] out_data [N_PORTS];
  logic              out_val  [N_PORTS];
  logic              out_en   [N_PORTS];

  // Scoreboard, keyed by output * N_PORTS + source
  logic [DATA_W-1:0] exp_q   [N_PORTS*N_PORTS][$];
  int                exp_acc [N_PORTS*N_PORTS][$];  // Acceptance cycle
  int                arr_src [N_PORTS][$];          // Arrival order of sources
  int                rx_count [N_PORTS];
  int                cyc;
  int                errors;
  int                err_start;
  int                tests_run;
  int                tests_failed;
  bit                check_latency;
  string             cur_test;
  logic [DATA_W-1:0] stage_data [N_PORTS];
  logic              stage_val  [N_PORTS];
  logic [31:0]       rng_state;

  tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(3)) u_clock_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  mesh_router #(
    .DATA_W(DATA_W), .COORD_W(COORD_W), .FIFO_DEPTH(FIFO_DEPTH),
    .ROUTER_X(ROUTER_X), .ROUTER_Y(ROUTER_Y)
  ) DUT (
    .clk        (clk),
    .i_rst_n    (rst_n),
    .i_in_data  (in_data),
    .i_in_val   (in_val),
    .o_in_en    (in_en),
    .o_out_data (out_data),
    .o_out_val  (out_val),
    .i_out_en   (out_en)
  );

  // Reference helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [DATA_W-1:0] make_flit(input int x, input int y, input int src,
                                                  input int seq);
    return {COORD_W'(x), COORD_W'(y), SEL_W'(src), SEQ_W'(seq)};
  endfunction

  // XY rule: X first, then Y, own tile goes to core
  function automatic int xy_route(input logic [DATA_W-1:0] flit);
    int dx;
    int dy;
    dx = int'(flit_dest_x(FLIT_MAX_W'(flit), DATA_W, COORD_W));
    dy = int'(flit_dest_y(FLIT_MAX_W'(flit), DATA_W, COORD_W));
    if (dx > ROUTER_X) return int'(PORT_E);
    if (dx < ROUTER_X) return int'(PORT_W);
    if (dy > ROUTER_Y) return int'(PORT_N);
    if (dy < ROUTER_Y) return int'(PORT_S);
    return int'(PORT_C);
  endfunction

  // Cycle counter and run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout: run passed %0d cycles", cyc);
      $display("Some tests failed");
      $finish;
    end
  end

  // Output monitor, checks data, order and latency per source queue
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    int src;
    int key;
    int lat;
    if (rst_n) begin
      for (int j = 0; j < N_PORTS; j++) begin
        if (out_val[j]) begin
          src = int'(out_data[j][SRC_LSB +: SEL_W]);
          rx_count[j]++;
          arr_src[j].push_back(src);
          key = j * N_PORTS + src;
          if (src >= N_PORTS || exp_q[key].size() == 0) begin
            $display("Test %s: unexpected flit %h on output %0d", cur_test, out_data[j], j);
            errors++;
          end else begin
            if (out_data[j] !== exp_q[key][0]) begin
              $display("FAIL %s: output %0d data expected %h actual %h",
                       cur_test, j, exp_q[key][0], out_data[j]);
              errors++;
            end
            lat = cyc - exp_acc[key][0];  // Edges from accept to valid sample
            if (check_latency && lat != 2) begin
              $display("FAIL %s: latency expected 2 actual %0d", cur_test, lat);
              errors++;
            end
            void'(exp_q[key].pop_front());
            void'(exp_acc[key].pop_front());
          end
        end
      end
    end
  end

  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic clear_stage();
    for (int p = 0; p < N_PORTS; p++) stage_val[p] = 1'b0;
  endtask

  task automatic stage(input int p, input logic [DATA_W-1:0] d);
    stage_val[p]  = 1'b1;
    stage_data[p] = d;
  endtask

  task automatic drive_stage();
    @(posedge clk);
    for (int p = 0; p < N_PORTS; p++) begin
      if (stage_val[p]) begin
        in_val[p]  <= 1'b1;
        in_data[p] <= stage_data[p];
      end
    end
  endtask

  // Holds each staged flit until its enable is seen at an edge
  task automatic wait_accept();
    bit pending;
    int key;
    pending = 1'b1;
    while (pending) begin
      @(posedge clk);
      pending = 1'b0;
      for (int p = 0; p < N_PORTS; p++) begin
        if (stage_val[p]) begin
          if (in_en[p]) begin
            key = xy_route(stage_data[p]) * N_PORTS + p;
            exp_q[key].push_back(stage_data[p]);
            exp_acc[key].push_back(cyc);
            stage_val[p] = 1'b0;
            in_val[p]    <= 1'b0;
          end else begin
            pending = 1'b1;
          end
        end
      end
    end
  endtask

  task automatic send_stage();
    drive_stage();
    wait_accept();
  endtask

  // Waits for every expected flit, then a few idle cycles for strays
  task automatic wait_drain();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int k = 0; k < N_PORTS * N_PORTS; k++) begin
        if (exp_q[k].size() != 0) busy = 1'b1;
      end
    end
    repeat (4) @(posedge clk);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == err_start) begin
      $display("PASS %s", cur_test);
    end else begin
      $display("Test %s finished with %0d errors", cur_test, errors - err_start);
      tests_failed++;
    end
  endtask

  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset();
    begin_test("reset");
    for (int p = 0; p < N_PORTS; p++) begin
      if (out_val[p] !== 1'b0) begin
        $display("FAIL %s: o_out_val[%0d] expected 0 actual %b", cur_test, p, out_val[p]);
        errors++;
      end
      if (in_en[p] !== 1'b1) begin
        $display("FAIL %s: o_in_en[%0d] expected 1 actual %b", cur_test, p, in_en[p]);
        errors++;
      end
    end
    end_test();
  endtask

  task automatic test_routing();
    int dx [5] = '{3, 1, 2, 2, 2};  // East, west, north, south, own tile
    int dy [5] = '{2, 2, 3, 1, 2};
    begin_test("routing");
    check_latency = 1'b1;
    for (int d = 0; d < 5; d++) begin
      rng_state = xorshift32(rng_state);
      clear_stage();
      stage(int'(PORT_C), make_flit(dx[d], dy[d], int'(PORT_C), int'(rng_state[SEQ_W-1:0])));
      send_stage();
      wait_drain();
    end
    check_latency = 1'b0;
    end_test();
  endtask

  task automatic test_fairness();
    int left [N_PORTS];
    int ptr;
    int win;
    begin_test("fairness");
    arr_src[int'(PORT_C)].delete();
    for (int r = 0; r < 3; r++) begin
      clear_stage();
      for (int p = 1; p < N_PORTS; p++) stage(p, make_flit(ROUTER_X, ROUTER_Y, p, r));
      send_stage();
    end
    wait_drain();
    // Rotating priority model, all four inputs keep requesting
    left = '{0, 3, 3, 3, 3};
    ptr  = 0;
    for (int k = 0; k < 12; k++) begin
      win = -1;
      for (int off = 0; off < N_PORTS; off++) begin
        if (win < 0 && left[(ptr + off) % N_PORTS] > 0) win = (ptr + off) % N_PORTS;
      end
      left[win]--;
      ptr = (win + 1) % N_PORTS;
      if (k >= arr_src[int'(PORT_C)].size()) begin
        $display("Test %s: core output delivered only %0d flits", cur_test, k);
        errors++;
        break;
      end else if (arr_src[int'(PORT_C)][k] != win) begin
        $display("FAIL %s: grant %0d expected source %0d actual %0d",
                 cur_test, k, win, arr_src[int'(PORT_C)][k]);
        errors++;
      end
    end
    end_test();
  endtask

  task automatic test_parallel();
    begin_test("parallel");
    check_latency = 1'b1;
    clear_stage();
    stage(int'(PORT_N), make_flit(2, 1, int'(PORT_N), 11));  // To south
    stage(int'(PORT_E), make_flit(1, 2, int'(PORT_E), 22));  // To west
    stage(int'(PORT_S), make_flit(2, 3, int'(PORT_S), 33));  // To north
    stage(int'(PORT_W), make_flit(3, 2, int'(PORT_W), 44));  // To east
    send_stage();
    wait_drain();
    check_latency = 1'b0;
    end_test();
  endtask

  task automatic test_backpressure();
    int base;
    begin_test("backpressure");
    @(posedge clk);
    out_en[int'(PORT_E)] <= 1'b0;
    base = rx_count[int'(PORT_E)];
    for (int n = 0; n < FIFO_DEPTH; n++) begin
      clear_stage();
      stage(int'(PORT_W), make_flit(3, 2, int'(PORT_W), n));
      send_stage();
    end
    clear_stage();
    stage(int'(PORT_W), make_flit(3, 2, int'(PORT_W), FIFO_DEPTH));
    drive_stage();
    repeat (5) begin
      @(posedge clk);
      if (in_en[int'(PORT_W)] !== 1'b0) begin
        $display("FAIL %s: o_in_en[W] expected 0 actual %b", cur_test, in_en[int'(PORT_W)]);
        errors++;
      end
      if (rx_count[int'(PORT_E)] != base) begin
        $display("Test %s: east valid seen while held off", cur_test);
        errors++;
      end
    end
    out_en[int'(PORT_E)] <= 1'b1;
    wait_accept();
    wait_drain();
    if (rx_count[int'(PORT_E)] - base != FIFO_DEPTH + 1) begin
      $display("FAIL %s: east count expected %0d actual %0d",
               cur_test, FIFO_DEPTH + 1, rx_count[int'(PORT_E)] - base);
      errors++;
    end
    end_test();
  endtask

  task automatic test_random();
    int sent;
    int base;
    int total;
    logic [31:0] mask;
    begin_test("random");
    sent = 0;
    base = 0;
    for (int j = 0; j < N_PORTS; j++) base += rx_count[j];
    while (sent < N_RANDOM) begin
      clear_stage();
      rng_state = xorshift32(rng_state);
      mask      = rng_state;
      for (int p = 0; p < N_PORTS; p++) begin
        if (mask[p] && sent < N_RANDOM) begin
          rng_state = xorshift32(rng_state);
          stage(p, make_flit(int'(rng_state[2:0]), int'(rng_state[5:3]), p, sent));
          sent++;
        end
      end
      send_stage();
    end
    wait_drain();
    total = 0;
    for (int j = 0; j < N_PORTS; j++) total += rx_count[j];
    if (total - base != N_RANDOM) begin
      $display("FAIL %s: received expected %0d actual %0d", cur_test, N_RANDOM, total - base);
      errors++;
    end
    end_test();
  endtask

  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    for (int p = 0; p < N_PORTS; p++) begin
      in_data[p]  = '0;
      in_val[p]   = 1'b0;
      out_en[p]   = 1'b1;
      rx_count[p] = 0;
    end
    cyc           = 0;
    errors        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    check_latency = 1'b0;
    cur_test      = "init";
    rng_state     = 32'd55;
    clear_stage();
    wait (rst_n === 1'b1);
    @(posedge clk);
    test_reset();
    test_routing();
    test_fairness();
    test_parallel();
    test_backpressure();
    test_random();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tb_mesh_router_assert.sv ====
// Arbitration checks on the switch controller
// Bound into every mesh_switch_control instance

module tb_mesh_router_assert (
  input logic                         clk,
  input logic                         i_rst_n,
  input logic [mesh_pkg::N_PORTS-1:0] i_req_matrix   [mesh_pkg::N_PORTS],  // [output][input]
  input logic [mesh_pkg::N_PORTS-1:0] i_grant_matrix [mesh_pkg::N_PORTS]
);

  import mesh_pkg::*;

  logic [N_PORTS-1:0] in_grants [N_PORTS];  // [input][output], transposed

  for (genvar i = 0; i < N_PORTS; i++) begin : g_tr
    for (genvar j = 0; j < N_PORTS; j++) begin : g_col
      assign in_grants[i][j] = i_grant_matrix[j][i];
    end
  end

  for (genvar j = 0; j < N_PORTS; j++) begin : g_out
    a_grant_onehot : assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(i_grant_matrix[j]))
      else $error("Output %0d grant not one-hot", j);

    // Grant needs a masked request behind it
    a_grant_req : assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_grant_matrix[j] & ~i_req_matrix[j]) == '0)
      else $error("Output %0d granted without request", j);
  end

  for (genvar i = 0; i < N_PORTS; i++) begin : g_in
    a_single_out : assert property (@(posedge clk) disable iff (!i_rst_n)
      $onehot0(in_grants[i]))
      else $error("Input %0d granted on two outputs", i);
  end

endmodule

bind mesh_switch_control tb_mesh_router_assert u_assert (
  .clk            (clk),
  .i_rst_n        (i_rst_n),
  .i_req_matrix   (req_matrix),
  .i_grant_matrix (grant_matrix)
);

// ==== tb_clock_gen.sv ====
// Testbench clock and power-on reset generator

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Reset held low for a few rising edges
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

// ==== mesh_router.sv ====
// Five-port XY mesh router top level
// Input units, switch controller and output stage

module mesh_router #(
  parameter int DATA_W     = 16,
  parameter int COORD_W    = 3,
  parameter int FIFO_DEPTH = 4,
  parameter int ROUTER_X   = 2,
  parameter int ROUTER_Y   = 2
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic [DATA_W-1:0] i_in_data  [mesh_pkg::N_PORTS],  // From upstream
  input  logic              i_in_val   [mesh_pkg::N_PORTS],
  output logic              o_in_en    [mesh_pkg::N_PORTS],  // To upstream
  output logic [DATA_W-1:0] o_out_data [mesh_pkg::N_PORTS],  // To downstream
  output logic              o_out_val  [mesh_pkg::N_PORTS],
  input  logic              i_out_en   [mesh_pkg::N_PORTS]   // From downstream
);

  import mesh_pkg::*;

  logic [DATA_W-1:0]  head      [N_PORTS];  // FIFO heads into crossbar
  logic [N_PORTS-1:0] req       [N_PORTS];  // Route requests per input
  logic               pop       [N_PORTS];  // Grant back to input
  port_e              sel       [N_PORTS];  // Crossbar selects
  logic               grant_val [N_PORTS];

  // Input units
  // ----------------------------------------------------------------------
  for (genvar p = 0; p < N_PORTS; p++) begin : g_in
    mesh_input_unit #(
      .DATA_W     (DATA_W),
      .COORD_W    (COORD_W),
      .FIFO_DEPTH (FIFO_DEPTH),
      .ROUTER_X   (ROUTER_X),
      .ROUTER_Y   (ROUTER_Y)
    ) u_input_unit (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_data  (i_in_data[p]),
      .i_val   (i_in_val[p]),
      .o_en    (o_in_en[p]),
      .i_pop   (pop[p]),
      .o_head  (head[p]),
      .o_req   (req[p])
    );
  end

  // Switch control
  mesh_switch_control u_switch_control (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_out_en    (i_out_en),
    .i_req       (req),
    .o_sel       (sel),
    .o_grant_val (grant_val),
    .o_pop       (pop)
  );

  // Crossbar and output registers
  mesh_output_stage #(
    .DATA_W (DATA_W)
  ) u_output_stage (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_head      (head),
    .i_sel       (sel),
    .i_grant_val (grant_val),
    .o_data      (o_out_data),
    .o_val       (o_out_val)
  );

endmodule

// ==== mesh_output_stage.sv ====
// Crossbar multiplexers and registered output data / valid
// toward the downstream routers

module mesh_output_stage #(
  parameter int DATA_W = 16
) (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic [DATA_W-1:0] i_head      [mesh_pkg::N_PORTS],  // Per input
  input  mesh_pkg::port_e   i_sel       [mesh_pkg::N_PORTS],  // Per output
  input  logic              i_grant_val [mesh_pkg::N_PORTS],  // Per output
  output logic [DATA_W-1:0] o_data      [mesh_pkg::N_PORTS],
  output logic              o_val       [mesh_pkg::N_PORTS]
);

  import mesh_pkg::*;

  logic [DATA_W-1:0] xbar_data [N_PORTS];  // Mux outputs

  // Crossbar
  // ----------------------------------------------------------------------
  always_comb begin
    for (int j = 0; j < N_PORTS; j++) begin
      xbar_data[j] = i_head[i_sel[j]];
    end
  end

  // Output registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int j = 0; j < N_PORTS; j++) o_val[j] <= 1'b0;
    end else begin
      for (int j = 0; j < N_PORTS; j++) o_val[j] <= i_grant_val[j];  // One cycle per flit
    end
  end

  // Data holds between grants
  always_ff @(posedge clk) begin
    for (int j = 0; j < N_PORTS; j++) begin
      if (i_grant_val[j]) o_data[j] <= xbar_data[j];
    end
  end

endmodule

// ==== mesh_input_unit.sv ====
// Router input unit: circular flit FIFO and XY route
// computation on the head flit

module mesh_input_unit #(
  parameter int DATA_W     = 16,
  parameter int COORD_W    = 3,
  parameter int FIFO_DEPTH = 4,   // Power of two
  parameter int ROUTER_X   = 2,
  parameter int ROUTER_Y   = 2
) (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic [DATA_W-1:0]            i_data,   // Flit from upstream
  input  logic                         i_val,    // Upstream presents a flit
  output logic                         o_en,     // Room in the FIFO
  input  logic                         i_pop,    // Head granted this cycle
  output logic [DATA_W-1:0]            o_head,   // Head flit to crossbar
  output logic [mesh_pkg::N_PORTS-1:0] o_req     // One-hot output request
);

  import mesh_pkg::*;

  localparam int ADDR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W  = ADDR_W + 1;

  logic [DATA_W-1:0] fifo_mem [FIFO_DEPTH];  // Flit storage
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]  count;                  // Flits held
  logic              empty;
  logic              push;
  logic              pop;

  logic [COORD_MAX_W-1:0] dest_x;
  logic [COORD_MAX_W-1:0] dest_y;
  port_e                  route;              // XY result for the head

  // FIFO control
  // ----------------------------------------------------------------------
  assign empty = (count == '0);
  assign o_en  = (count != CNT_W'(FIFO_DEPTH));  // Not full
  assign push  = i_val && o_en;                  // Accept rule
  assign pop   = i_pop && !empty;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps naturally
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Both or neither
      endcase
    end
  end

  // Storage, written only on accept
  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= i_data;
  end

  assign o_head = fifo_mem[rd_ptr];

  // XY route of the head flit
  // ----------------------------------------------------------------------
  // X first, then Y, own coordinate goes to the core
  assign dest_x = flit_dest_x(FLIT_MAX_W'(o_head), DATA_W, COORD_W);
  assign dest_y = flit_dest_y(FLIT_MAX_W'(o_head), DATA_W, COORD_W);

  always_comb begin
    if (int'(dest_x) > ROUTER_X)
      route = PORT_E;
    else if (int'(dest_x) < ROUTER_X)
      route = PORT_W;
    else if (int'(dest_y) > ROUTER_Y)
      route = PORT_N;
    else if (int'(dest_y) < ROUTER_Y)
      route = PORT_S;
    else
      route = PORT_C;
  end

  // Request only while a flit waits
  always_comb begin
    o_req = '0;
    if (!empty) o_req[route] = 1'b1;
  end

endmodule

// ==== mesh_switch_control.sv ====
// Switch controller: request masking, per-output round-robin arbitration,
// crossbar select encoding and pop / grant-valid strobes

module mesh_switch_control (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic                         i_out_en    [mesh_pkg::N_PORTS],  // Downstream can take
  input  logic [mesh_pkg::N_PORTS-1:0] i_req       [mesh_pkg::N_PORTS],  // Per input, one-hot
  output mesh_pkg::port_e              o_sel       [mesh_pkg::N_PORTS],  // Per output, winner
  output logic                         o_grant_val [mesh_pkg::N_PORTS],  // Per output
  output logic                         o_pop       [mesh_pkg::N_PORTS]   // Per input
);

  import mesh_pkg::*;

  logic [N_PORTS-1:0] req_matrix   [N_PORTS];  // [output][input], masked by enable
  logic [N_PORTS-1:0] grant_matrix [N_PORTS];  // [output][input]

  // Request matrix
  // ----------------------------------------------------------------------
  // An output only sees requests while its downstream enable is high
  always_comb begin
    for (int j = 0; j < N_PORTS; j++) begin
      for (int i = 0; i < N_PORTS; i++) begin
        req_matrix[j][i] = i_req[i][j] && i_out_en[j];
      end
    end
  end

  // One arbiter per output column
  // ----------------------------------------------------------------------
  for (genvar j = 0; j < N_PORTS; j++) begin : g_arb
    mesh_round_robin_arbiter u_arb (
      .clk       (clk),
      .i_rst_n   (i_rst_n),
      .i_request (req_matrix[j]),
      .o_grant   (grant_matrix[j])
    );
  end

  // Strobes
  // ----------------------------------------------------------------------
  always_comb begin
    for (int j = 0; j < N_PORTS; j++) begin
      o_grant_val[j] = |grant_matrix[j];  // Output gets a flit next edge
    end
    for (int i = 0; i < N_PORTS; i++) begin
      o_pop[i] = 1'b0;
      for (int j = 0; j < N_PORTS; j++) begin
        o_pop[i] = o_pop[i] | grant_matrix[j][i];  // At most one output per input
      end
    end
  end

  // Crossbar select
  // ----------------------------------------------------------------------
  // Grant is one-hot, so encoding is a plain index search
  always_comb begin
    for (int j = 0; j < N_PORTS; j++) begin
      o_sel[j] = PORT_C;  // Don't care when no grant
      for (int i = 0; i < N_PORTS; i++) begin
        if (grant_matrix[j][i]) o_sel[j] = port_e'(SEL_W'(i));
      end
    end
  end

endmodule

// ==== mesh_round_robin_arbiter.sv ====
// Round-robin arbiter over the five router inputs
// Combinational grant, registered priority pointer

module mesh_round_robin_arbiter (
  input  logic                         clk,
  input  logic                         i_rst_n,
  input  logic [mesh_pkg::N_PORTS-1:0] i_request,  // One bit per requesting input
  output logic [mesh_pkg::N_PORTS-1:0] o_grant     // One-hot or zero
);

  import mesh_pkg::*;

  localparam int PTR_W = $clog2(N_PORTS);

  logic [PTR_W-1:0] ptr;        // Highest priority input this cycle
  logic [PTR_W-1:0] win_idx;    // Index of the winner
  logic             win_found;  // Some request was granted

  // Cyclic search starting at the pointer
  // ----------------------------------------------------------------------
  always_comb begin
    int idx;
    o_grant   = '0;
    win_idx   = '0;
    win_found = 1'b0;
    for (int off = 0; off < N_PORTS; off++) begin
      idx = int'(ptr) + off;
      if (idx >= N_PORTS) idx = idx - N_PORTS;  // Wrap past input 4
      if (!win_found && i_request[idx]) begin
        win_found = 1'b1;
        win_idx   = PTR_W'(idx);
      end
    end
    if (win_found) o_grant[win_idx] = 1'b1;
  end

  // Pointer moves to the input after the winner
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ptr <= '0;
    end else if (win_found) begin
      if (win_idx == PTR_W'(N_PORTS - 1))
        ptr <= '0;                  // Wrap to input 0
      else
        ptr <= win_idx + 1'b1;
    end
    // No request, pointer holds
  end

endmodule

// ==== mesh_pkg.sv ====
// Shared router constants, port direction enum
// and flit destination field helpers

package mesh_pkg;

  // Router geometry
  // ----------------------------------------------------------------------
  localparam int N_PORTS     = 5;   // c, n, e, s, w
  localparam int SEL_W       = 3;   // Crossbar select / port code width
  localparam int FLIT_MAX_W  = 64;  // Widest flit the helpers accept
  localparam int COORD_MAX_W = 8;   // Widest coordinate the helpers return

  // Port code, doubles as crossbar select and route result
  typedef enum logic [SEL_W-1:0] {
    PORT_C = 3'd0,  // Local core
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_S = 3'd3,
    PORT_W = 3'd4
  } port_e;

  // Destination X lives in the top coord_w bits of the flit
  function automatic logic [COORD_MAX_W-1:0] flit_dest_x(input logic [FLIT_MAX_W-1:0] flit,
                                                         input int data_w,
                                                         input int coord_w);
    logic [FLIT_MAX_W-1:0] shifted;
    shifted = flit >> (data_w - coord_w);
    return shifted[COORD_MAX_W-1:0] & COORD_MAX_W'((1 << coord_w) - 1);
  endfunction

  // Destination Y sits just below X
  function automatic logic [COORD_MAX_W-1:0] flit_dest_y(input logic [FLIT_MAX_W-1:0] flit,
                                                         input int data_w,
                                                         input int coord_w);
    logic [FLIT_MAX_W-1:0] shifted;
    shifted = flit >> (data_w - 2 * coord_w);
    return shifted[COORD_MAX_W-1:0] & COORD_MAX_W'((1 << coord_w) - 1);
  endfunction

endpackage
